/* design/zf_pkg.sv */
`default_nettype none

package zf_pkg;

    // settings bus address and data word
    typedef logic [31:0] word_t;

    // one beat of the packet stream
    typedef logic [63:0] beat_t;

    // page number taken from the settings address
    typedef logic [2:0] page_t;

    // --------------------------------------------------
    // settings page map
    // --------------------------------------------------
    localparam page_t PAGE_ARB    = 3'd0;
    localparam page_t PAGE_CORE   = 3'd2;
    localparam page_t PAGE_LOOKUP = 3'd3;
    localparam page_t PAGE_BUF    = 3'd4;

    // readback for pages with nothing behind them
    localparam word_t DEADBEEF = 32'hdeadbeef;

    // word offsets inside the arbiter page
    localparam int ARB_STATUS_OFS   = 8;
    localparam int ARB_OVERFLOW_OFS = 9;

endpackage

`default_nettype wire

/* design/zf_settings_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface zf_settings_if;

    // write side, one strobe per write
    logic          set_stb;
    zf_pkg::word_t set_addr;
    zf_pkg::word_t set_data;

    // readback side, data is combinational from rb_addr
    logic          rb_stb;
    zf_pkg::word_t rb_addr;
    zf_pkg::word_t rb_data;

    // page decoder end
    modport decoder (
        output set_stb, set_addr, set_data, rb_stb, rb_addr,
        input  rb_data
    );

    // register block end
    modport block (
        input  set_stb, set_addr, set_data, rb_stb, rb_addr,
        output rb_data
    );

endinterface

`default_nettype wire

/* design/zf_stream_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface zf_stream_if;

    zf_pkg::beat_t tdata;
    logic          tlast;
    logic          tvalid;
    logic          tready;

    // beat moves when tvalid and tready are both high
    modport source (output tdata, tlast, tvalid, input tready);
    modport sink (input tdata, tlast, tvalid, output tready);

endinterface

`default_nettype wire

/* design/zf_settings_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module zf_settings_decode #(
    parameter int PAGE_WIDTH = 10
) (
    input  logic          i_set_stb,
    input  zf_pkg::word_t i_set_addr,
    input  zf_pkg::word_t i_set_data,
    input  logic          i_rb_stb,
    input  zf_pkg::word_t i_rb_addr,
    input  zf_pkg::word_t i_core_rb_data,
    output zf_pkg::word_t o_rb_data,
    output logic          o_core_set_stb,
    output zf_pkg::word_t o_core_set_addr,
    output zf_pkg::word_t o_core_set_data,
    zf_settings_if.decoder arb_bus,
    zf_settings_if.decoder lookup_bus,
    zf_settings_if.decoder buf_bus
);

    zf_pkg::page_t set_page;
    zf_pkg::page_t rb_page;

    // page is the three bits just above the page offset
    assign set_page = i_set_addr[PAGE_WIDTH+2:PAGE_WIDTH];
    assign rb_page  = i_rb_addr[PAGE_WIDTH+2:PAGE_WIDTH];

    // --------------------------------------------------
    // write strobes, one target per page
    // --------------------------------------------------
    assign arb_bus.set_stb    = i_set_stb && (set_page == zf_pkg::PAGE_ARB);
    assign lookup_bus.set_stb = i_set_stb && (set_page == zf_pkg::PAGE_LOOKUP);
    assign buf_bus.set_stb    = i_set_stb && (set_page == zf_pkg::PAGE_BUF);
    assign o_core_set_stb     = i_set_stb && (set_page == zf_pkg::PAGE_CORE);

    // address and data fan out to every block
    assign arb_bus.set_addr    = i_set_addr;
    assign arb_bus.set_data    = i_set_data;
    assign lookup_bus.set_addr = i_set_addr;
    assign lookup_bus.set_data = i_set_data;
    assign buf_bus.set_addr    = i_set_addr;
    assign buf_bus.set_data    = i_set_data;

    // core only sees the low byte of the address
    assign o_core_set_addr = {24'd0, i_set_addr[7:0]};
    assign o_core_set_data = i_set_data;

    // --------------------------------------------------
    // readback
    // --------------------------------------------------
    assign arb_bus.rb_stb     = i_rb_stb && (rb_page == zf_pkg::PAGE_ARB);
    assign lookup_bus.rb_stb  = i_rb_stb && (rb_page == zf_pkg::PAGE_LOOKUP);
    assign buf_bus.rb_stb     = i_rb_stb && (rb_page == zf_pkg::PAGE_BUF);
    assign arb_bus.rb_addr    = i_rb_addr;
    assign lookup_bus.rb_addr = i_rb_addr;
    assign buf_bus.rb_addr    = i_rb_addr;

    always_comb begin
        case (rb_page)
            zf_pkg::PAGE_ARB:    o_rb_data = arb_bus.rb_data;
            zf_pkg::PAGE_CORE:   o_rb_data = i_core_rb_data;
            // lookup answers with the unmapped value itself
            zf_pkg::PAGE_LOOKUP: o_rb_data = lookup_bus.rb_data;
            zf_pkg::PAGE_BUF:    o_rb_data = buf_bus.rb_data;
            default:             o_rb_data = zf_pkg::DEADBEEF;
        endcase
    end

endmodule

`default_nettype wire

/* design/cvita_dest_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module cvita_dest_lookup #(
    parameter int DEST_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    zf_settings_if.block          set_bus,
    zf_stream_if.sink             in_s,
    zf_stream_if.source           out_s,
    output logic [DEST_WIDTH-1:0] o_tdest
);

    // endpoint to stream table, 256 entries
    logic [DEST_WIDTH-1:0] dest_table [256];

    // high while the next beat starts a packet
    logic                  sof;
    logic [DEST_WIDTH-1:0] dest_held;
    logic [DEST_WIDTH-1:0] dest_now;
    logic                  beat_fire;

    assign beat_fire = in_s.tvalid && out_s.tready;

    // --------------------------------------------------
    // table fill from the settings bus
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (set_bus.set_stb) begin
            // word index within the page
            dest_table[set_bus.set_addr[9:2]] <= set_bus.set_data[DEST_WIDTH-1:0];
        end
    end

    // endpoint is the low byte of the first word
    assign dest_now = dest_table[in_s.tdata[7:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
        end else if (beat_fire) begin
            sof <= in_s.tlast;
        end
    end

    // keep the first beat's result for the rest of the packet
    always_ff @(posedge clk) begin
        if (beat_fire && sof) begin
            dest_held <= dest_now;
        end
    end

    assign o_tdest = sof ? dest_now : dest_held;

    // beats go through untouched
    assign out_s.tdata  = in_s.tdata;
    assign out_s.tlast  = in_s.tlast;
    assign out_s.tvalid = in_s.tvalid;
    assign in_s.tready  = out_s.tready;

    // table is write only
    assign set_bus.rb_data = zf_pkg::DEADBEEF;

endmodule

`default_nettype wire

/* design/zf_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module zf_arbiter #(
    parameter int STREAMS_WIDTH = 2,
    parameter int CMDFIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    zf_settings_if.block             set_bus,
    input  logic [STREAMS_WIDTH-1:0] i_ext_stream,
    input  logic                     i_stream_valid,
    input  logic                     i_cmd_ready,
    input  logic                     i_sts_stb,
    input  zf_pkg::word_t            i_sts_count,
    output logic                     o_cmd_valid,
    output zf_pkg::word_t            o_cmd_addr
);

    localparam int STREAMS   = 1 << STREAMS_WIDTH;
    localparam int PTR_WIDTH = $clog2(CMDFIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(CMDFIFO_DEPTH + 1);

    // per stream queues of buffer addresses
    zf_pkg::word_t        queue_mem [STREAMS][CMDFIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr [STREAMS];
    logic [PTR_WIDTH-1:0] rd_ptr [STREAMS];
    logic [CNT_WIDTH-1:0] count [STREAMS];
    logic [STREAMS-1:0]   full;
    logic [STREAMS-1:0]   push;
    logic [STREAMS-1:0]   pushed;
    logic [STREAMS-1:0]   pop;
    logic [STREAMS-1:0]   overflow;

    logic [7:0]               set_ofs;
    logic [7:0]               rb_ofs;
    logic                     issue;
    logic                     cmd_fire;
    logic                     busy;
    logic [STREAMS_WIDTH-1:0] cur_stream;
    zf_pkg::word_t            last_sts;

    function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(CMDFIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign set_ofs  = set_bus.set_addr[9:2];
    assign rb_ofs   = set_bus.rb_addr[9:2];
    assign cmd_fire = o_cmd_valid && i_cmd_ready;

    // only one command in flight until its status comes back
    assign issue = !o_cmd_valid && !busy && i_stream_valid && (count[i_ext_stream] != '0);

    always_comb begin
        for (int s = 0; s < STREAMS; s++) begin
            full[s]   = (count[s] == CNT_WIDTH'(CMDFIFO_DEPTH));
            push[s]   = set_bus.set_stb && (set_ofs == 8'(s));
            pushed[s] = push[s] && !full[s];
            pop[s]    = issue && (i_ext_stream == STREAMS_WIDTH'(s));
        end
    end

    // --------------------------------------------------
    // queue pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < STREAMS; s++) begin
                wr_ptr[s] <= '0;
                rd_ptr[s] <= '0;
                count[s]  <= '0;
            end
            overflow <= '0;
        end else begin
            for (int s = 0; s < STREAMS; s++) begin
                if (pushed[s]) begin
                    wr_ptr[s] <= ptr_next(wr_ptr[s]);
                end
                if (pop[s]) begin
                    rd_ptr[s] <= ptr_next(rd_ptr[s]);
                end
                // full push is lost, flag it until reset
                if (push[s] && full[s]) begin
                    overflow[s] <= 1'b1;
                end
                count[s] <= count[s] + CNT_WIDTH'(pushed[s]) - CNT_WIDTH'(pop[s]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < STREAMS; s++) begin
            if (pushed[s]) begin
                queue_mem[s][wr_ptr[s]] <= set_bus.set_data;
            end
        end
    end

    // --------------------------------------------------
    // command issue and status capture
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            o_cmd_valid <= 1'b0;
            busy        <= 1'b0;
            last_sts    <= '0;
        end else begin
            if (issue) begin
                o_cmd_valid <= 1'b1;
            end else if (cmd_fire) begin
                o_cmd_valid <= 1'b0;
            end
            if (cmd_fire) begin
                busy <= 1'b1;
            end else if (i_sts_stb) begin
                busy <= 1'b0;
            end
            // stream on top, beat count below
            if (i_sts_stb) begin
                last_sts <= {8'(cur_stream), i_sts_count[23:0]};
            end
        end
    end

    // head of the queue for the waiting packet
    always_ff @(posedge clk) begin
        if (issue) begin
            o_cmd_addr <= queue_mem[i_ext_stream][rd_ptr[i_ext_stream]];
            cur_stream <= i_ext_stream;
        end
    end

    always_comb begin
        set_bus.rb_data = '0;
        if (rb_ofs < 8'(STREAMS)) begin
            set_bus.rb_data = 32'(count[rb_ofs[STREAMS_WIDTH-1:0]]);
        end else if (rb_ofs == 8'(zf_pkg::ARB_STATUS_OFS)) begin
            set_bus.rb_data = last_sts;
        end else if (rb_ofs == 8'(zf_pkg::ARB_OVERFLOW_OFS)) begin
            set_bus.rb_data = 32'(overflow);
        end
    end

endmodule

`default_nettype wire

/* design/zf_packet_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module zf_packet_writer #(
    parameter int BUF_WIDTH = 6
) (
    input  logic          clk,
    input  logic          rst,
    zf_stream_if.sink     data_s,
    zf_settings_if.block  set_bus,
    input  logic          i_cmd_valid,
    input  zf_pkg::word_t i_cmd_addr,
    output logic          o_cmd_ready,
    output logic          o_sts_stb,
    output zf_pkg::word_t o_sts_count
);

    // init holds off commands for one cycle out of reset
    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_ACTIVE,
        ST_DONE
    } state_t;

    state_t               state;
    logic [BUF_WIDTH-1:0] wr_ptr;
    zf_pkg::word_t        beat_cnt;
    zf_pkg::beat_t        buf_mem [2**BUF_WIDTH];
    zf_pkg::beat_t        rb_word;
    logic                 cmd_fire;
    logic                 beat_fire;

    assign o_cmd_ready   = (state == ST_IDLE);
    // beats only flow between command and tlast
    assign data_s.tready = (state == ST_ACTIVE);
    assign cmd_fire      = i_cmd_valid && o_cmd_ready;
    assign beat_fire     = data_s.tvalid && data_s.tready;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_INIT;
        end else begin
            case (state)
                ST_INIT:   state <= ST_IDLE;
                ST_IDLE:   if (cmd_fire) state <= ST_ACTIVE;
                ST_ACTIVE: if (beat_fire && data_s.tlast) state <= ST_DONE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // base from the command, then one word per beat
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            wr_ptr   <= i_cmd_addr[BUF_WIDTH-1:0];
            beat_cnt <= '0;
        end else if (beat_fire) begin
            // wraps at the buffer depth
            wr_ptr   <= wr_ptr + 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) begin
            buf_mem[wr_ptr] <= data_s.tdata;
        end
    end

    // status for one cycle after the tlast beat
    assign o_sts_stb   = (state == ST_DONE);
    assign o_sts_count = beat_cnt;

    // --------------------------------------------------
    // buffer readback
    // --------------------------------------------------
    // word from bits above 3, bit 2 picks the upper half
    assign rb_word         = buf_mem[set_bus.rb_addr[BUF_WIDTH+2:3]];
    assign set_bus.rb_data = set_bus.rb_addr[2] ? rb_word[63:32] : rb_word[31:0];

endmodule

`default_nettype wire

/* design/zf_host_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module zf_host_bridge #(
    parameter int PAGE_WIDTH    = 10,
    parameter int STREAMS_WIDTH = 2,
    parameter int CMDFIFO_DEPTH = 4,
    parameter int BUF_WIDTH     = 6
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_set_stb,
    input  zf_pkg::word_t i_set_addr,
    input  zf_pkg::word_t i_set_data,
    input  logic          i_rb_stb,
    input  zf_pkg::word_t i_rb_addr,
    output zf_pkg::word_t o_rb_data,
    input  zf_pkg::beat_t i_s2h_tdata,
    input  logic          i_s2h_tlast,
    input  logic          i_s2h_tvalid,
    output logic          o_s2h_tready,
    output logic          o_core_set_stb,
    output zf_pkg::word_t o_core_set_addr,
    output zf_pkg::word_t o_core_set_data,
    input  zf_pkg::word_t i_core_rb_data,
    output logic          o_event_irq
);

    // --------------------------------------------------
    // internal buses
    // --------------------------------------------------
    zf_settings_if arb_set ();
    zf_settings_if lookup_set ();
    zf_settings_if buf_set ();
    zf_stream_if   s2h_in ();
    zf_stream_if   s2h_pkt ();

    logic [STREAMS_WIDTH-1:0] which_stream;
    logic                     cmd_valid;
    logic                     cmd_ready;
    zf_pkg::word_t            cmd_addr;
    logic                     sts_stb;
    zf_pkg::word_t            sts_count;

    // incoming stream onto its bus
    assign s2h_in.tdata  = i_s2h_tdata;
    assign s2h_in.tlast  = i_s2h_tlast;
    assign s2h_in.tvalid = i_s2h_tvalid;
    assign o_s2h_tready  = s2h_in.tready;

    // every finished packet raises the event
    assign o_event_irq = sts_stb;

    zf_settings_decode #(.PAGE_WIDTH(PAGE_WIDTH)) u_decode (
        .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
        .i_rb_stb(i_rb_stb), .i_rb_addr(i_rb_addr), .i_core_rb_data(i_core_rb_data),
        .o_rb_data(o_rb_data), .o_core_set_stb(o_core_set_stb),
        .o_core_set_addr(o_core_set_addr), .o_core_set_data(o_core_set_data),
        .arb_bus(arb_set), .lookup_bus(lookup_set), .buf_bus(buf_set)
    );

    cvita_dest_lookup #(.DEST_WIDTH(STREAMS_WIDTH)) u_lookup (
        .clk(clk), .rst(rst), .set_bus(lookup_set),
        .in_s(s2h_in), .out_s(s2h_pkt), .o_tdest(which_stream)
    );

    // packet waiting is the lookup output valid
    zf_arbiter #(
        .STREAMS_WIDTH(STREAMS_WIDTH),
        .CMDFIFO_DEPTH(CMDFIFO_DEPTH)
    ) u_arbiter (
        .clk(clk), .rst(rst), .set_bus(arb_set),
        .i_ext_stream(which_stream), .i_stream_valid(s2h_pkt.tvalid),
        .i_cmd_ready(cmd_ready), .i_sts_stb(sts_stb), .i_sts_count(sts_count),
        .o_cmd_valid(cmd_valid), .o_cmd_addr(cmd_addr)
    );

    zf_packet_writer #(.BUF_WIDTH(BUF_WIDTH)) u_writer (
        .clk(clk), .rst(rst), .data_s(s2h_pkt), .set_bus(buf_set),
        .i_cmd_valid(cmd_valid), .i_cmd_addr(cmd_addr), .o_cmd_ready(cmd_ready),
        .o_sts_stb(sts_stb), .o_sts_count(sts_count)
    );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_zf_host_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_zf_host_bridge;

    localparam int PAGE_WIDTH    = 10;
    localparam int STREAMS_WIDTH = 2;
    localparam int CMDFIFO_DEPTH = 4;
    localparam int BUF_WIDTH     = 6;
    localparam int STREAMS       = 1 << STREAMS_WIDTH;
    localparam int BUF_WORDS     = 1 << BUF_WIDTH;
    localparam int DRIVE_NS      = 2;
    localparam int NUM_ENDPOINTS = 8;
    localparam int NUM_PKTS      = 16;
    localparam int DECODE_OPS    = 24;
    localparam int STALL_CYCLES  = 50;
    // generous per packet budget for the queue push, the beats and the status read
    localparam int PKT_CYCLES    = 40;
    // about ten times the expected length of all tests
    localparam int TIMEOUT_CYCLES = 10 * (16 + DECODE_OPS * 12 + 3 * NUM_PKTS * PKT_CYCLES
                                          + 12 * BUF_WORDS + STALL_CYCLES);

    logic          clk;
    logic          rst;
    logic          set_stb;
    zf_pkg::word_t set_addr;
    zf_pkg::word_t set_data;
    logic          rb_stb;
    zf_pkg::word_t rb_addr;
    zf_pkg::word_t rb_data;
    zf_pkg::beat_t s2h_tdata;
    logic          s2h_tlast;
    logic          s2h_tvalid;
    logic          s2h_tready;
    logic          core_set_stb;
    zf_pkg::word_t core_set_addr;
    zf_pkg::word_t core_set_data;
    zf_pkg::word_t core_rb_data;
    logic          event_irq;

    // --------------------------------------------------
    // model state
    // --------------------------------------------------
    logic [STREAMS_WIDTH-1:0] model_lut [256];
    zf_pkg::word_t            model_queue [STREAMS][CMDFIFO_DEPTH];
    int                       q_head [STREAMS];
    int                       q_count [STREAMS];
    logic [STREAMS-1:0]       model_ovf;
    zf_pkg::beat_t            model_buf [BUF_WORDS];
    logic [BUF_WORDS-1:0]     buf_written;
    logic [7:0]               endpoints [NUM_ENDPOINTS];

    int          irq_count;
    int          pkt_count;
    int          errors;
    int          checks;
    int          tests;
    int          cycle_count;
    logic [31:0] rng_state;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk_gen (.clk(clk), .rst(rst));

    zf_host_bridge #(
        .PAGE_WIDTH(PAGE_WIDTH),
        .STREAMS_WIDTH(STREAMS_WIDTH),
        .CMDFIFO_DEPTH(CMDFIFO_DEPTH),
        .BUF_WIDTH(BUF_WIDTH)
    ) i_dut (
        .clk(clk), .rst(rst),
        .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
        .i_rb_stb(rb_stb), .i_rb_addr(rb_addr), .o_rb_data(rb_data),
        .i_s2h_tdata(s2h_tdata), .i_s2h_tlast(s2h_tlast), .i_s2h_tvalid(s2h_tvalid),
        .o_s2h_tready(s2h_tready),
        .o_core_set_stb(core_set_stb), .o_core_set_addr(core_set_addr),
        .o_core_set_data(core_set_data), .i_core_rb_data(core_rb_data),
        .o_event_irq(event_irq)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // byte address of a word offset inside a page
    function automatic zf_pkg::word_t page_addr(input zf_pkg::page_t page,
                                                input logic [7:0] ofs);
        return (zf_pkg::word_t'(page) << PAGE_WIDTH) | {22'd0, ofs, 2'b00};
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-14s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    endtask

    task automatic write_setting(input zf_pkg::word_t addr, input zf_pkg::word_t data);
        @(posedge clk);
        #(DRIVE_NS);
        set_stb  = 1'b1;
        set_addr = addr;
        set_data = data;
        @(posedge clk);
        #(DRIVE_NS);
        set_stb = 1'b0;
    endtask

    // every read drives a fresh core readback word and samples mid cycle
    task automatic read_setting(input zf_pkg::word_t addr, output zf_pkg::word_t data);
        @(posedge clk);
        #(DRIVE_NS);
        rb_stb       = 1'b1;
        rb_addr      = addr;
        core_rb_data = rand_word();
        @(negedge clk);
        data = rb_data;
        @(posedge clk);
        #(DRIVE_NS);
        rb_stb = 1'b0;
    endtask

    task automatic set_endpoint(input logic [7:0] ep, input int stream);
        zf_pkg::word_t data;
        data = rand_word();
        data[STREAMS_WIDTH-1:0] = STREAMS_WIDTH'(stream);
        write_setting(page_addr(zf_pkg::PAGE_LOOKUP, ep), data);
        model_lut[ep] = data[STREAMS_WIDTH-1:0];
    endtask

    // full queue drops the push and flags overflow
    task automatic push_addr(input int stream, input zf_pkg::word_t data);
        write_setting(page_addr(zf_pkg::PAGE_ARB, 8'(stream)), data);
        if (q_count[stream] < CMDFIFO_DEPTH) begin
            model_queue[stream][(q_head[stream] + q_count[stream]) % CMDFIFO_DEPTH] = data;
            q_count[stream]++;
        end else begin
            model_ovf[stream] = 1'b1;
        end
    endtask

    // with stall set, the queue is filled only after the packet has waited
    task automatic send_packet(input logic [7:0] ep, input int len, input int stall);
        zf_pkg::beat_t beats [8];
        int            stream;
        int            base;
        zf_pkg::word_t status;
        stream = model_lut[ep];
        for (int k = 0; k < len; k++) begin
            beats[k] = {rand_word(), rand_word()};
        end
        beats[0][7:0] = ep;
        for (int k = 0; k < len; k++) begin
            @(posedge clk);
            #(DRIVE_NS);
            s2h_tdata  = beats[k];
            s2h_tlast  = (k == len - 1);
            s2h_tvalid = 1'b1;
            if (k == 0 && stall > 0) begin
                repeat (stall) begin
                    @(negedge clk);
                    check_equal(s2h_tready, 1'b0, "tready with empty queue");
                end
                push_addr(stream, rand_word());
            end
            // beat moves on the edge after tready is seen
            @(negedge clk);
            while (!s2h_tready) @(negedge clk);
        end
        @(posedge clk);
        #(DRIVE_NS);
        s2h_tvalid = 1'b0;
        s2h_tlast  = 1'b0;
        // head of the model queue is the base
        base = model_queue[stream][q_head[stream]][BUF_WIDTH-1:0];
        q_head[stream] = (q_head[stream] + 1) % CMDFIFO_DEPTH;
        q_count[stream]--;
        for (int k = 0; k < len; k++) begin
            model_buf[(base + k) % BUF_WORDS]   = beats[k];
            buf_written[(base + k) % BUF_WORDS] = 1'b1;
        end
        pkt_count++;
        @(negedge clk);
        while (!event_irq) @(negedge clk);
        read_setting(page_addr(zf_pkg::PAGE_ARB, 8'(zf_pkg::ARB_STATUS_OFS)), status);
        check_equal(status, {8'(stream), 24'(len)}, "status word");
    endtask

    // two reads per word with the low half first
    task automatic check_buffer();
        zf_pkg::word_t lo;
        zf_pkg::word_t hi;
        for (int w = 0; w < BUF_WORDS; w++) begin
            if (buf_written[w]) begin
                read_setting(page_addr(zf_pkg::PAGE_BUF, 8'(w * 2)), lo);
                read_setting(page_addr(zf_pkg::PAGE_BUF, 8'(w * 2 + 1)), hi);
                check_equal({hi, lo}, model_buf[w], $sformatf("buffer word %0d", w));
            end
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_page_decode();
        int            errs;
        zf_pkg::word_t addr;
        zf_pkg::word_t data;
        zf_pkg::word_t got;
        errs = errors;
        @(negedge clk);
        check_equal(s2h_tready, 1'b0, "tready after reset");
        check_equal(event_irq, 1'b0, "irq after reset");
        check_equal(core_set_stb, 1'b0, "core strobe after reset");
        for (int i = 0; i < DECODE_OPS; i++) begin
            addr = page_addr(zf_pkg::PAGE_CORE, 8'(rand_word())) | (rand_word() & 32'h3);
            data = rand_word();
            @(posedge clk);
            #(DRIVE_NS);
            set_stb  = 1'b1;
            set_addr = addr;
            set_data = data;
            @(negedge clk);
            check_equal(core_set_stb, 1'b1, "core strobe");
            check_equal(core_set_addr, addr & 32'h0000_00ff, "core address");
            check_equal(core_set_data, data, "core data");
            @(posedge clk);
            #(DRIVE_NS);
            set_stb = 1'b0;
            @(negedge clk);
            check_equal(core_set_stb, 1'b0, "core strobe length");
            read_setting(addr, got);
            check_equal(got, core_rb_data, "core readback");
        end
        // pages with nothing behind them
        for (int p = 1; p < 8; p++) begin
            if (p != 2 && p != 4) begin
                read_setting(page_addr(zf_pkg::page_t'(p), 8'(rand_word())), got);
                check_equal(got, zf_pkg::DEADBEEF, $sformatf("readback of page %0d", p));
            end
        end
        finish_test("page_decode", errs);
    endtask

    task automatic test_routing();
        int         errs;
        logic [7:0] ep;
        errs = errors;
        for (int i = 0; i < NUM_ENDPOINTS; i++) begin
            endpoints[i] = 8'(rand_word());
            set_endpoint(endpoints[i], int'(rand_word() % STREAMS));
        end
        for (int i = 0; i < NUM_PKTS; i++) begin
            ep = endpoints[rand_word() % NUM_ENDPOINTS];
            push_addr(model_lut[ep], rand_word());
            send_packet(ep, 1 + int'(rand_word() % 8), 0);
        end
        check_buffer();
        finish_test("routing", errs);
    endtask

    // two commands queued ahead of their packets
    task automatic test_status();
        int         errs;
        logic [7:0] ep;
        errs = errors;
        for (int i = 0; i < NUM_PKTS / 2; i++) begin
            ep = endpoints[rand_word() % NUM_ENDPOINTS];
            push_addr(model_lut[ep], rand_word());
            push_addr(model_lut[ep], rand_word());
            send_packet(ep, 1 + int'(rand_word() % 8), 0);
            send_packet(ep, 1 + int'(rand_word() % 8), 0);
        end
        check_equal(irq_count, pkt_count, "interrupt count");
        finish_test("status_irq", errs);
    endtask

    task automatic test_overflow();
        int            errs;
        int            s;
        logic [7:0]    ep;
        zf_pkg::word_t got;
        errs = errors;
        s  = int'(rand_word() % STREAMS);
        ep = 8'(rand_word());
        set_endpoint(ep, s);
        for (int i = 0; i < CMDFIFO_DEPTH + 2; i++) begin
            push_addr(s, rand_word());
        end
        for (int t = 0; t < STREAMS; t++) begin
            read_setting(page_addr(zf_pkg::PAGE_ARB, 8'(t)), got);
            check_equal(got, q_count[t], $sformatf("occupancy of stream %0d", t));
        end
        // only the pushed stream flags
        read_setting(page_addr(zf_pkg::PAGE_ARB, 8'(zf_pkg::ARB_OVERFLOW_OFS)), got);
        check_equal(got, 32'(model_ovf), "overflow bits");
        // draining must never reach a dropped address
        for (int i = 0; i < CMDFIFO_DEPTH; i++) begin
            send_packet(ep, 1 + int'(rand_word() % 8), 0);
        end
        read_setting(page_addr(zf_pkg::PAGE_ARB, 8'(s)), got);
        check_equal(got, 32'd0, "occupancy after drain");
        check_buffer();
        finish_test("overflow", errs);
    endtask

    task automatic test_back_pressure();
        int         errs;
        logic [7:0] ep;
        errs = errors;
        ep = 8'(rand_word());
        set_endpoint(ep, int'(rand_word() % STREAMS));
        send_packet(ep, 1 + int'(rand_word() % 8), STALL_CYCLES);
        check_buffer();
        finish_test("back_pressure", errs);
    endtask

    // --------------------------------------------------
    // monitors and run control
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rst && event_irq) begin
            irq_count++;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run hung: no finish after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rng_state    = 32'd42385;
        set_stb      = 1'b0;
        set_addr     = '0;
        set_data     = '0;
        rb_stb       = 1'b0;
        rb_addr      = '0;
        s2h_tdata    = '0;
        s2h_tlast    = 1'b0;
        s2h_tvalid   = 1'b0;
        core_rb_data = '0;
        model_ovf    = '0;
        buf_written  = '0;
        irq_count    = 0;
        pkt_count    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        for (int s = 0; s < STREAMS; s++) begin
            q_head[s]  = 0;
            q_count[s] = 0;
        end
        while (rst !== 1'b0) @(posedge clk);
        test_page_decode();
        test_routing();
        test_status();
        test_overflow();
        test_back_pressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/zf_pkg.sv
design/zf_settings_if.sv
design/zf_stream_if.sv
design/zf_settings_decode.sv
design/cvita_dest_lookup.sv
design/zf_arbiter.sv
design/zf_packet_writer.sv
design/zf_host_bridge.sv
tests/tb_clk_gen.sv
tests/tb_zf_host_bridge.sv

/* Bender.yml */
package:
  name: zf_host_bridge

sources:
  - design/zf_pkg.sv
  - design/zf_settings_if.sv
  - design/zf_stream_if.sv
  - design/zf_settings_decode.sv
  - design/cvita_dest_lookup.sv
  - design/zf_arbiter.sv
  - design/zf_packet_writer.sv
  - design/zf_host_bridge.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_zf_host_bridge.sv
